// ==== source/capture_pkg.sv ====
package capture_pkg;

    //====================================================================
    // Sizes
    //====================================================================

    // Stream and memory word
    localparam int DATA_WID = 32;

    // Packet memory, power of two so the last address is all ones
    localparam int MEM_DEPTH = 256;
    localparam int MEM_ADDR_WID = 8;

    // Metadata word carried alongside each packet
    localparam int META_WID = 32;

    // Register port address, top bit opens the memory window
    localparam int REG_ADDR_WID = 9;

    //====================================================================
    // Register map
    //====================================================================

    localparam logic [REG_ADDR_WID-1:0] REG_STATUS     = 9'd0;
    localparam logic [REG_ADDR_WID-1:0] REG_CONTROL    = 9'd1;
    localparam logic [REG_ADDR_WID-1:0] REG_MEM_SIZE   = 9'd2;
    localparam logic [REG_ADDR_WID-1:0] REG_META_WIDTH = 9'd3;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_WORDS  = 9'd4;
    localparam logic [REG_ADDR_WID-1:0] REG_PKT_META   = 9'd5;
    localparam logic [REG_ADDR_WID-1:0] REG_LAST_BYTES = 9'd6;

    // Memory words start here, word index in the low address bits
    localparam logic [REG_ADDR_WID-1:0] MEM_WINDOW_BASE = 9'd256;

    //====================================================================
    // Types
    //====================================================================

    // One stream beat, last_bytes of 0 means a full word
    typedef struct packed {
        logic                valid;
        logic                sop;
        logic                eop;
        logic [1:0]          last_bytes;
        logic [DATA_WID-1:0] data;
        logic [META_WID-1:0] meta;
    } packet_beat_t;

    // Register request, single-cycle strobes
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        logic [REG_ADDR_WID-1:0] addr;
        logic [DATA_WID-1:0]     wdata;
    } reg_req_t;

    // Register response, one cycle after the read strobe
    typedef struct packed {
        logic                rd_valid;
        logic [DATA_WID-1:0] rdata;
    } reg_rsp_t;

    // Capture sequencing
    typedef enum logic [2:0] {
        INIT    = 3'd0,
        IDLE    = 3'd1,
        ARMED   = 3'd2,
        CAPTURE = 3'd3,
        DONE    = 3'd4
    } capture_state_t;

    // Ready sits in bit 0 so the STATUS word is this struct zero-extended
    typedef struct packed {
        logic truncated;
        logic done;
        logic armed;
        logic ready;
    } capture_status_t;

    // Software command pulses from CONTROL writes
    typedef struct packed {
        logic arm;
        logic clear;
    } ctrl_cmd_t;

endpackage

// ==== source/capture_fsm.sv ====
`timescale 1ns/10ps

module capture_fsm
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                en,
    input  capture_pkg::packet_beat_t           beat,
    input  capture_pkg::ctrl_cmd_t              cmd,
    input  logic                                wrap,
    input  logic [capture_pkg::MEM_ADDR_WID-1:0] count,
    output logic                                count_clear,
    output logic                                count_step,
    output logic                                mem_we,
    output capture_pkg::capture_status_t        status,
    output logic [capture_pkg::MEM_ADDR_WID:0]  pkt_words,
    output logic [capture_pkg::META_WID-1:0]    pkt_meta,
    output logic [1:0]                          last_bytes
);

    capture_pkg::capture_state_t state;
    capture_pkg::capture_state_t state_d;

    logic start;       // First beat of a packet accepted while armed
    logic last;        // End of the packet being captured
    logic go_idle;     // Software releases a finished capture
    logic full;        // Last memory address already holds a word
    logic trunc_flag;

    //====================================================================
    // Beat qualification
    //====================================================================

    // Only a fresh sop with en high opens a capture
    assign start = (state == capture_pkg::ARMED) && beat.valid && beat.sop && en;

    // Single-word packet ends in the same beat it starts
    assign last = (start && beat.eop)
        || ((state == capture_pkg::CAPTURE) && beat.valid && beat.eop);

    assign go_idle = (state == capture_pkg::DONE) && cmd.clear;

    //====================================================================
    // Next state and memory / counter controls
    //====================================================================

    always_comb
    begin
        state_d = state;
        mem_we = 1'b0;
        case (state)
            capture_pkg::INIT:
            begin
                // Zero sweep, one word per cycle
                mem_we = 1'b1;
                if (wrap)
                begin
                    state_d = capture_pkg::IDLE;
                end
            end
            capture_pkg::IDLE:
            begin
                if (cmd.arm)
                begin
                    state_d = capture_pkg::ARMED;
                end
            end
            capture_pkg::ARMED:
            begin
                mem_we = start;
                if (start)
                begin
                    state_d = beat.eop ? capture_pkg::DONE : capture_pkg::CAPTURE;
                end
                else if (cmd.clear)
                begin
                    state_d = capture_pkg::IDLE;   // disarm
                end
            end
            capture_pkg::CAPTURE:
            begin
                // Overflow words are dropped, no back-pressure exists
                mem_we = beat.valid && !full;
                if (last)
                begin
                    state_d = capture_pkg::DONE;
                end
            end
            capture_pkg::DONE:
            begin
                if (cmd.clear)
                begin
                    state_d = capture_pkg::IDLE;
                end
            end
            default:
            begin
                state_d = capture_pkg::INIT;
            end
        endcase
    end

    // Counter advances with every write and saturates at the last address
    assign count_step = mem_we;

    // Parked at 0 in IDLE, also reset at the end of the sweep
    assign count_clear = (state == capture_pkg::IDLE)
        || ((state == capture_pkg::INIT) && wrap);

    //====================================================================
    // State, overflow tracking and result
    //====================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= capture_pkg::INIT;
            full <= 1'b0;
            trunc_flag <= 1'b0;
            pkt_words <= '0;
            pkt_meta <= '0;
            last_bytes <= '0;
        end
        else
        begin
            state <= state_d;

            // Cleared between captures
            if (state == capture_pkg::IDLE)
            begin
                full <= 1'b0;
            end
            else if (mem_we && wrap && (state != capture_pkg::INIT))
            begin
                full <= 1'b1;
            end

            if (go_idle)
            begin
                trunc_flag <= 1'b0;
            end
            else if ((state == capture_pkg::CAPTURE) && beat.valid && full)
            begin
                trunc_flag <= 1'b1;
            end

            if (go_idle)
            begin
                pkt_words <= '0;
                pkt_meta <= '0;
                last_bytes <= '0;
            end
            else if (last)
            begin
                // Saturated count plus one gives MEM_DEPTH on overflow
                pkt_words <= {1'b0, count} + 1'b1;
                pkt_meta <= beat.meta;
                last_bytes <= beat.last_bytes;
            end
        end
    end

    // Status decoded from state
    assign status.ready = (state != capture_pkg::INIT);
    assign status.armed = (state == capture_pkg::ARMED) || (state == capture_pkg::CAPTURE);
    assign status.done = (state == capture_pkg::DONE);
    assign status.truncated = trunc_flag;

endmodule

// ==== source/capture_counter.sv ====
`timescale 1ns/10ps

module capture_counter
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 count_clear,
    input  logic                                 count_step,
    output logic [capture_pkg::MEM_ADDR_WID-1:0] count,
    output logic                                 wrap
);

    //====================================================================
    // Word address counter
    //====================================================================

    // Memory depth is a power of two, last address is all ones
    assign wrap = &count;

    // Clear wins over step
    // Holds at the last address instead of rolling back to 0
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            count <= '0;
        end
        else if (count_clear)
        begin
            count <= '0;
        end
        else if (count_step && !wrap)
        begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== source/packet_mem.sv ====
`timescale 1ns/10ps

module packet_mem
(
    input  logic                                 clk,
    input  logic                                 we,
    input  logic [capture_pkg::MEM_ADDR_WID-1:0] waddr,
    input  logic [capture_pkg::MEM_ADDR_WID-1:0] raddr,
    input  logic [capture_pkg::DATA_WID-1:0]     wdata,
    output logic [capture_pkg::DATA_WID-1:0]     rdata
);

    //====================================================================
    // Storage
    //====================================================================

    logic [capture_pkg::DATA_WID-1:0] mem [capture_pkg::MEM_DEPTH];

    // Write port, one word per cycle
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read, one cycle of latency
    // Same-address collision returns the old word
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

// ==== source/capture_regs.sv ====
`timescale 1ns/10ps

module capture_regs
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  capture_pkg::reg_req_t                req,
    output capture_pkg::reg_rsp_t                rsp,
    output capture_pkg::ctrl_cmd_t               cmd,
    input  capture_pkg::capture_status_t         status,
    input  logic [capture_pkg::MEM_ADDR_WID:0]   pkt_words,
    input  logic [capture_pkg::META_WID-1:0]     pkt_meta,
    input  logic [1:0]                           last_bytes,
    output logic [capture_pkg::MEM_ADDR_WID-1:0] mem_raddr,
    input  logic [capture_pkg::DATA_WID-1:0]     mem_rdata
);

    logic                             ctrl_wr;
    logic                             mem_sel;
    logic [capture_pkg::DATA_WID-1:0] reg_rdata_d;
    logic [capture_pkg::DATA_WID-1:0] reg_rdata_q;
    logic                             mem_sel_q;
    logic                             rd_valid_q;

    //====================================================================
    // Write decode
    //====================================================================

    assign ctrl_wr = req.wr && (req.addr == capture_pkg::REG_CONTROL);

    // Pulses reach the FSM in the strobe cycle
    assign cmd.arm = ctrl_wr && req.wdata[0];
    assign cmd.clear = ctrl_wr && req.wdata[1];

    //====================================================================
    // Read path
    //====================================================================

    assign mem_sel = (req.addr >= capture_pkg::MEM_WINDOW_BASE);

    // Memory registers this address itself, lines up with reg_rdata_q
    assign mem_raddr = req.addr[capture_pkg::MEM_ADDR_WID-1:0];

    always_comb
    begin
        reg_rdata_d = '0;
        case (req.addr)
            capture_pkg::REG_STATUS:
            begin
                reg_rdata_d[$bits(capture_pkg::capture_status_t)-1:0] = status;
            end
            capture_pkg::REG_MEM_SIZE:
            begin
                // Size in bytes
                reg_rdata_d = capture_pkg::MEM_DEPTH * (capture_pkg::DATA_WID / 8);
            end
            capture_pkg::REG_META_WIDTH:
            begin
                reg_rdata_d = capture_pkg::META_WID;
            end
            capture_pkg::REG_PKT_WORDS:
            begin
                reg_rdata_d[capture_pkg::MEM_ADDR_WID:0] = pkt_words;
            end
            capture_pkg::REG_PKT_META:
            begin
                reg_rdata_d = pkt_meta;
            end
            capture_pkg::REG_LAST_BYTES:
            begin
                reg_rdata_d[1:0] = last_bytes;
            end
            default:
            begin
                // CONTROL and unmapped addresses read 0
                reg_rdata_d = '0;
            end
        endcase
    end

    // Read data word, captured on the strobe only
    always_ff @(posedge clk)
    begin
        if (req.rd)
        begin
            reg_rdata_q <= reg_rdata_d;
        end
    end

    // Reads during the zero sweep get no answer
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_valid_q <= 1'b0;
            mem_sel_q <= 1'b0;
        end
        else
        begin
            rd_valid_q <= req.rd && status.ready;
            if (req.rd)
            begin
                mem_sel_q <= mem_sel;
            end
        end
    end

    assign rsp.rd_valid = rd_valid_q;
    assign rsp.rdata = mem_sel_q ? mem_rdata : reg_rdata_q;

endmodule

// ==== source/packet_capture.sv ====
`timescale 1ns/10ps

module packet_capture
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      en,
    input  capture_pkg::packet_beat_t beat,
    input  capture_pkg::reg_req_t     req,
    output capture_pkg::reg_rsp_t     rsp
);

    //====================================================================
    // Internal connections
    //====================================================================

    capture_pkg::ctrl_cmd_t            cmd;
    capture_pkg::capture_status_t      status;
    logic [capture_pkg::MEM_ADDR_WID:0] pkt_words;
    logic [capture_pkg::META_WID-1:0]  pkt_meta;
    logic [1:0]                        last_bytes;

    logic                                 count_clear;
    logic                                 count_step;
    logic [capture_pkg::MEM_ADDR_WID-1:0] count;
    logic                                 wrap;

    logic                                 mem_we;
    logic [capture_pkg::DATA_WID-1:0]     mem_wdata;
    logic [capture_pkg::MEM_ADDR_WID-1:0] mem_raddr;
    logic [capture_pkg::DATA_WID-1:0]     mem_rdata;

    // Zeros during the sweep, stream data afterwards
    assign mem_wdata = status.ready ? beat.data : '0;

    //====================================================================
    // Blocks
    //====================================================================

    // Sequencing
    capture_fsm u_fsm
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .beat        (beat),
        .cmd         (cmd),
        .wrap        (wrap),
        .count       (count),
        .count_clear (count_clear),
        .count_step  (count_step),
        .mem_we      (mem_we),
        .status      (status),
        .pkt_words   (pkt_words),
        .pkt_meta    (pkt_meta),
        .last_bytes  (last_bytes)
    );

    // Write address for both the sweep and the capture
    capture_counter u_counter
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .count_clear (count_clear),
        .count_step  (count_step),
        .count       (count),
        .wrap        (wrap)
    );

    // Write side from the counter, read side from the register port
    packet_mem u_mem
    (
        .clk   (clk),
        .we    (mem_we),
        .waddr (count),
        .raddr (mem_raddr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // Software access
    capture_regs u_regs
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .rsp        (rsp),
        .cmd        (cmd),
        .status     (status),
        .pkt_words  (pkt_words),
        .pkt_meta   (pkt_meta),
        .last_bytes (last_bytes),
        .mem_raddr  (mem_raddr),
        .mem_rdata  (mem_rdata)
    );

endmodule

// ==== bench/tb_packet_capture.sv ====
`timescale 1ns/10ps

module tb_packet_capture;

    // One row of the test table
    typedef struct {
        string      name;
        int         len;         // Words in the packet
        logic [1:0] last_bytes;
        logic       en;
        int         arm;         // 0 none, 1 before the packet, 2 inside a leading packet
        logic       exp_cap;     // Packet expected to land in memory
    } test_entry_t;

    logic                       clk;
    logic                       rst_n;
    logic                       en;
    capture_pkg::packet_beat_t  beat;
    capture_pkg::reg_req_t      req;
    capture_pkg::reg_rsp_t      rsp;

    test_entry_t                      tests [10];
    logic [capture_pkg::DATA_WID-1:0] pkt_data [512];
    logic [capture_pkg::DATA_WID-1:0] exp_mem [capture_pkg::MEM_DEPTH];
    logic [capture_pkg::META_WID-1:0] pkt_meta;
    logic                             armed_model;
    int                               err_count;
    int                               tests_failed;
    int                               cycle_count;
    int                               cycle_limit;

    packet_capture u_dut
    (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .beat  (beat),
        .req   (req),
        .rsp   (rsp)
    );

    //======================================================================
    // Clock and watchdog
    //======================================================================

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Limit stays 0 until the table is loaded
    initial
    begin
        cycle_count = 0;
        while ((cycle_limit == 0) || (cycle_count < cycle_limit))
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    //======================================================================
    // Compare tasks
    //======================================================================

    task automatic check_status(input string name, input capture_pkg::capture_status_t exp_val,
        input capture_pkg::capture_status_t act_val);
        if (act_val !== exp_val)
        begin
            $display("ERROR %s: expected %b actual %b", name, exp_val, act_val);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input logic [capture_pkg::DATA_WID-1:0] exp_val,
        input logic [capture_pkg::DATA_WID-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("ERROR %s: expected %h actual %h", name, exp_val, act_val);
            err_count++;
        end
    endtask

    task automatic check_meta(input string name, input logic [capture_pkg::META_WID-1:0] exp_val,
        input logic [capture_pkg::META_WID-1:0] act_val);
        if (act_val !== exp_val)
        begin
            $display("ERROR %s: expected %h actual %h", name, exp_val, act_val);
            err_count++;
        end
    endtask

    //======================================================================
    // Register port and stream drivers
    //======================================================================

    // Starts and ends on a falling edge
    task automatic read_reg(input logic [capture_pkg::REG_ADDR_WID-1:0] addr,
        output logic [capture_pkg::DATA_WID-1:0] data, output logic got);
        req.rd = 1'b1;
        req.addr = addr;
        @(negedge clk);
        req.rd = 1'b0;
        // Answer belongs to exactly the edge after the strobe
        got = rsp.rd_valid;
        data = rsp.rdata;
    endtask

    task automatic read_answered(input string name,
        input logic [capture_pkg::REG_ADDR_WID-1:0] addr,
        output logic [capture_pkg::DATA_WID-1:0] data);
        logic got;
        read_reg(addr, data, got);
        if (!got)
        begin
            $display("%s: read of address %0d got no response", name, addr);
            err_count++;
        end
    endtask

    task automatic read_status(input string name, output capture_pkg::capture_status_t st);
        logic [capture_pkg::DATA_WID-1:0] data;
        read_answered(name, capture_pkg::REG_STATUS, data);
        st = data[$bits(capture_pkg::capture_status_t)-1:0];
    endtask

    task automatic write_reg(input logic [capture_pkg::REG_ADDR_WID-1:0] addr,
        input logic [capture_pkg::DATA_WID-1:0] data);
        req.wr = 1'b1;
        req.addr = addr;
        req.wdata = data;
        @(negedge clk);
        req.wr = 1'b0;
        req.wdata = '0;
        // No read strobe was pending over this edge
        if (rsp.rd_valid)
        begin
            $display("Write to address %0d: read response appeared without a read", addr);
            err_count++;
        end
    endtask

    // Reads words 0 to words-1 through the memory window
    task automatic check_memory(input string name, input int words);
        logic [capture_pkg::DATA_WID-1:0] data;
        for (int i = 0; i < words; i++)
        begin
            read_answered(name, capture_pkg::MEM_WINDOW_BASE + 9'(i), data);
            check_word($sformatf("%s word %0d", name, i), exp_mem[i], data);
        end
    endtask

    task automatic make_packet(input int len);
        for (int i = 0; i < len; i++)
        begin
            pkt_data[i] = $urandom();
        end
        pkt_meta = $urandom();
    endtask

    // Back-to-back beats with an optional arm pulse on beat arm_at
    task automatic send_packet(input int len, input logic [1:0] lb, input logic en_level,
        input int arm_at);
        for (int i = 0; i < len; i++)
        begin
            beat.valid = 1'b1;
            beat.sop = (i == 0);
            beat.eop = (i == len - 1);
            beat.last_bytes = (i == len - 1) ? lb : 2'd0;
            beat.data = pkt_data[i];
            beat.meta = pkt_meta;
            en = en_level;
            req.wr = (i == arm_at);
            req.addr = capture_pkg::REG_CONTROL;
            req.wdata = 32'd1;
            @(negedge clk);
        end
        beat = '0;
        en = 1'b1;
        req.wr = 1'b0;
        req.wdata = '0;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("Test %s: passed", name);
        end
        else
        begin
            $display("Test %s: failed with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    //======================================================================
    // Test table and run limit
    //======================================================================

    task automatic load_table();
        tests[0] = '{"single_1word",   1,   2'd1, 1'b1, 1, 1'b1};
        tests[1] = '{"single_37",      37,  2'd0, 1'b1, 1, 1'b1};
        tests[2] = '{"stream_a",       12,  2'd2, 1'b1, 1, 1'b1};
        tests[3] = '{"stream_b",       40,  2'd3, 1'b1, 1, 1'b1};
        tests[4] = '{"not_armed",      20,  2'd1, 1'b1, 0, 1'b0};
        tests[5] = '{"en_low",         9,   2'd2, 1'b0, 1, 1'b0};
        tests[6] = '{"en_high_next",   15,  2'd0, 1'b1, 0, 1'b1};
        tests[7] = '{"truncate_300",   300, 2'd3, 1'b1, 1, 1'b1};
        tests[8] = '{"mid_packet_arm", 25,  2'd1, 1'b1, 2, 1'b1};
        tests[9] = '{"exact_fill",     256, 2'd0, 1'b1, 1, 1'b1};
    endtask

    // Init sweep, margin, packet beats and readback reads times 4
    function automatic int run_limit();
        int total;
        int words;
        total = capture_pkg::MEM_DEPTH + 200;
        total += 4 * (capture_pkg::MEM_DEPTH + 8);
        foreach (tests[i])
        begin
            words = (tests[i].len > capture_pkg::MEM_DEPTH) ? capture_pkg::MEM_DEPTH : tests[i].len;
            total += tests[i].len + 4 * (words + 16);
            if (tests[i].arm == 2)
            begin
                total += tests[i].len;
            end
        end
        return total;
    endfunction

    //======================================================================
    // Test sequences
    //======================================================================

    task automatic run_init_checks();
        capture_pkg::capture_status_t st;
        capture_pkg::capture_status_t exp_st;
        logic [capture_pkg::DATA_WID-1:0] data;
        logic got;
        int errs_before;
        int attempts;
        errs_before = err_count;
        // Read during the zero sweep gets no answer and shows ready low
        read_reg(capture_pkg::REG_STATUS, data, got);
        if (got)
        begin
            $display("init_status: read answered during memory initialization");
            err_count++;
        end
        check_status("init_status", '0, data[$bits(capture_pkg::capture_status_t)-1:0]);
        attempts = 0;
        st = '0;
        while (!st.ready && (attempts < 2 * capture_pkg::MEM_DEPTH))
        begin
            read_reg(capture_pkg::REG_STATUS, data, got);
            if (got)
            begin
                st = data[$bits(capture_pkg::capture_status_t)-1:0];
            end
            attempts++;
        end
        if (!st.ready)
        begin
            $display("init_ready: ready never came up after initialization");
            err_count++;
        end
        exp_st = '0;
        exp_st.ready = 1'b1;
        check_status("init_ready", exp_st, st);
        read_answered("mem_size", capture_pkg::REG_MEM_SIZE, data);
        check_word("mem_size", 32'd1024, data);
        read_answered("meta_width", capture_pkg::REG_META_WIDTH, data);
        check_word("meta_width", 32'd32, data);
        check_memory("init_zero", capture_pkg::MEM_DEPTH);
        report_test("reset_init", errs_before);
    endtask

    task automatic run_test(input int idx);
        test_entry_t t;
        capture_pkg::capture_status_t exp_st;
        capture_pkg::capture_status_t st;
        logic [capture_pkg::DATA_WID-1:0] data;
        int words;
        int errs_before;
        int polls;
        t = tests[idx];
        errs_before = err_count;
        words = (t.len > capture_pkg::MEM_DEPTH) ? capture_pkg::MEM_DEPTH : t.len;
        if (t.arm == 2)
        begin
            // Leading packet is not captured and the arm lands halfway through
            make_packet(t.len);
            send_packet(t.len, t.last_bytes, 1'b1, t.len / 2);
            armed_model = 1'b1;
        end
        else if (t.arm == 1)
        begin
            write_reg(capture_pkg::REG_CONTROL, 32'd1);
            armed_model = 1'b1;
        end
        make_packet(t.len);
        send_packet(t.len, t.last_bytes, t.en, -1);
        exp_st = '0;
        exp_st.ready = 1'b1;
        if (t.exp_cap)
        begin
            // Overflow words never reach memory
            for (int i = 0; i < words; i++)
            begin
                exp_mem[i] = pkt_data[i];
            end
            exp_st.done = 1'b1;
            exp_st.truncated = (t.len > capture_pkg::MEM_DEPTH);
            polls = 0;
            st = '0;
            while (!st.done && (polls < 8))
            begin
                read_status(t.name, st);
                polls++;
            end
            if (!st.done)
            begin
                $display("%s: capture never reported done", t.name);
                err_count++;
            end
        end
        else
        begin
            exp_st.armed = armed_model;
            read_status(t.name, st);
        end
        check_status($sformatf("%s status", t.name), exp_st, st);
        // Result reads 0 when nothing was captured since the last clear
        read_answered(t.name, capture_pkg::REG_PKT_WORDS, data);
        check_word($sformatf("%s pkt_words", t.name), t.exp_cap ? 32'(words) : 32'd0, data);
        read_answered(t.name, capture_pkg::REG_PKT_META, data);
        check_meta($sformatf("%s pkt_meta", t.name), t.exp_cap ? pkt_meta : '0, data);
        read_answered(t.name, capture_pkg::REG_LAST_BYTES, data);
        check_word($sformatf("%s last_bytes", t.name), t.exp_cap ? {30'd0, t.last_bytes} : 32'd0,
            data);
        check_memory(t.name, words);
        if (t.exp_cap)
        begin
            write_reg(capture_pkg::REG_CONTROL, 32'd2);
            armed_model = 1'b0;
            exp_st = '0;
            exp_st.ready = 1'b1;
            read_status(t.name, st);
            check_status($sformatf("%s status after clear", t.name), exp_st, st);
            read_answered(t.name, capture_pkg::REG_PKT_WORDS, data);
            check_word($sformatf("%s pkt_words after clear", t.name), 32'd0, data);
        end
        report_test(t.name, errs_before);
    endtask

    //======================================================================
    // Main sequence
    //======================================================================

    initial
    begin
        rst_n = 1'b0;
        en = 1'b1;
        beat = '0;
        // Idle beats carry nonzero data during the zero sweep
        beat.data = 32'hffff_ffff;
        req = '0;
        err_count = 0;
        tests_failed = 0;
        armed_model = 1'b0;
        void'($urandom(32'hd677));
        for (int i = 0; i < capture_pkg::MEM_DEPTH; i++)
        begin
            exp_mem[i] = '0;
        end
        load_table();
        cycle_limit = run_limit();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        run_init_checks();
        beat = '0;
        for (int i = 0; i < $size(tests); i++)
        begin
            run_test(i);
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors",
            $size(tests) + 1, tests_failed, err_count);
        if (err_count == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/capture_pkg.sv
source/capture_fsm.sv
source/capture_counter.sv
source/packet_mem.sv
source/capture_regs.sv
source/packet_capture.sv
bench/tb_packet_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

# Compile everything from the file list
verilator --binary --timing -Wno-fatal --top-module tb_packet_capture \
    -f verilog.f -o tb_packet_capture > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

# Run, keep the whole transcript
./obj_dir/tb_packet_capture > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }

cat sim.log

# Pass only when the pass line is in the log
grep -qF '** PASS **' sim.log \
    && echo "Result: passed" \
    || { echo "Result: failed"; exit 1; }
